//--- design/dec_bus_if.sv
// one decoded instruction inside the DEC cycle; purely combinational, no handshake
`default_nettype none

interface dec_bus_if (
	input wire [dec_pkg::xlen-1:0] pc // pc of the instruction in decode
);

	dec_pkg::dec_instr_t       instr;
	logic [dec_pkg::xlen-1:0]  src1;
	logic [dec_pkg::xlen-1:0]  src2;

	modport decoder (
		output instr
	);

	modport operand (
		input  instr,
		input  pc,
		output src1,
		output src2
	);

	modport stage (
		input instr,
		input pc,
		input src1,
		input src2
	);

endinterface

`default_nettype wire

//--- design/dec_ex_reg.sv
// DEC-to-EX register; payload has no reset and is only meaningful while dec_valid is high
`default_nettype none

module dec_ex_reg (
	input wire                            cpu_clk,
	input wire                            cpu_rstn,
	dec_bus_if.stage                      bus,
	input wire                            accept,
	input wire                            ex_ready,
	input wire                            flush,
	output logic                          dec_valid,
	output dec_pkg::alu_op_t              alu_op_ex,
	output logic [dec_pkg::xlen-1:0]      src_data1_ex,
	output logic [dec_pkg::xlen-1:0]      src_data2_ex,
	output logic [dec_pkg::xlen-1:0]      pc_ex,
	output logic [dec_pkg::reg_idx_w-1:0] rd_ex,
	output logic                          rd_we_ex
);

	// control, rd_we_ex follows dec_valid down
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			dec_valid <= 1'b0;
			rd_we_ex  <= 1'b0;
		end
		else if (flush)
		begin
			dec_valid <= 1'b0;
			rd_we_ex  <= 1'b0;
		end
		else if (accept)
		begin
			dec_valid <= 1'b1;
			rd_we_ex  <= bus.instr.rd_we;
		end
		else if (ex_ready)
		begin
			dec_valid <= 1'b0; // taken by EX, nothing new
			rd_we_ex  <= 1'b0;
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		if (accept)
		begin
			alu_op_ex    <= bus.instr.alu_op;
			src_data1_ex <= bus.src1;
			src_data2_ex <= bus.src2;
			pc_ex        <= bus.pc;
			rd_ex        <= bus.instr.rd;
		end
	end

endmodule

`default_nettype wire

//--- design/dec_pkg.sv
// rv32i decode constants and types; only OP, OP-IMM, LUI, AUIPC and FENCE are recognised
`default_nettype none

package dec_pkg;

	localparam int xlen      = 32;
	localparam int reg_idx_w = 5;
	localparam int instr_w   = 32;
	localparam int gpr_num   = 1 << reg_idx_w; // x0 included

	// major opcodes, instr[6:0]
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_alu_rr = 7'b0110011;
	localparam logic [6:0] op_alu_ir = 7'b0010011;
	localparam logic [6:0] op_fence  = 7'b0001111;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;
	localparam logic [2:0] f3_fence   = 3'b000;
	localparam logic [2:0] f3_fence_i = 3'b001;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000; // sub / sra

	// decode stays not ready this many cycles after a fence
	localparam int fence_wait_cycles = 5;
	localparam int fence_cnt_w = $clog2(fence_wait_cycles + 1);
	localparam logic [fence_cnt_w-1:0] fence_cnt_init = fence_cnt_w'(fence_wait_cycles);

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_nop    // unknown opcode or fence
	} alu_op_t;

	typedef struct packed {
		alu_op_t              alu_op;
		logic [reg_idx_w-1:0] rs1;
		logic [reg_idx_w-1:0] rs2;
		logic [reg_idx_w-1:0] rd;
		logic                 rd_we;
		logic                 use_pc;    // auipc
		logic                 zero_src1; // lui
		logic                 use_imm;
		logic                 is_fence;
		logic [xlen-1:0]      imm;
	} dec_instr_t;

endpackage

`default_nettype wire

//--- design/dec_stage.sv
// rv32i decode stage top; one-cycle latency, valid/ready on both sides, no M, branch or memory ops
`default_nettype none

module dec_stage (
	input wire                            cpu_clk,
	input wire                            cpu_rstn,
	input wire                            if_valid,
	input wire [dec_pkg::instr_w-1:0]     instr_dec,
	input wire [dec_pkg::xlen-1:0]        pc_dec,
	output logic                          dec_ready,
	output logic                          dec_valid,
	input wire                            ex_ready,
	input wire                            flush,
	input wire [dec_pkg::xlen-1:0]        alu_result_ex,
	input wire                            wr_valid_wb,
	input wire [dec_pkg::reg_idx_w-1:0]   rd_wb,
	input wire [dec_pkg::xlen-1:0]        wr_data_wb,
	output dec_pkg::alu_op_t              alu_op_ex,
	output logic [dec_pkg::xlen-1:0]      src_data1_ex,
	output logic [dec_pkg::xlen-1:0]      src_data2_ex,
	output logic [dec_pkg::xlen-1:0]      pc_ex,
	output logic [dec_pkg::reg_idx_w-1:0] rd_ex,
	output logic                          rd_we_ex,
	output logic                          fence_dec
);

	logic [dec_pkg::xlen-1:0] rdata1;
	logic [dec_pkg::xlen-1:0] rdata2;
	logic                     accept;
	logic                     timer_load;
	logic                     timer_busy;

	dec_bus_if i_bus (.pc(pc_dec));

	instr_decoder i_decoder (
		.instr (instr_dec),
		.valid (if_valid),
		.bus   (i_bus)
	);

	gpr_file i_gpr (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr_valid (wr_valid_wb),
		.wr_idx   (rd_wb),
		.wr_data  (wr_data_wb),
		.rs1      (i_bus.instr.rs1),
		.rs2      (i_bus.instr.rs2),
		.rdata1   (rdata1),
		.rdata2   (rdata2)
	);

	operand_select i_operand (
		.bus           (i_bus),
		.rdata1        (rdata1),
		.rdata2        (rdata2),
		.ex_valid      (dec_valid),
		.rd_ex         (rd_ex),
		.rd_we_ex      (rd_we_ex),
		.alu_result_ex (alu_result_ex),
		.wr_valid_wb   (wr_valid_wb),
		.rd_wb         (rd_wb),
		.wr_data_wb    (wr_data_wb)
	);

	fence_timer i_fence_timer (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.load     (timer_load),
		.clear    (flush),
		.busy     (timer_busy)
	);

	stall_ctrl i_stall (
		.cpu_clk    (cpu_clk),
		.cpu_rstn   (cpu_rstn),
		.if_valid   (if_valid),
		.is_fence   (i_bus.instr.is_fence),
		.ex_ready   (ex_ready),
		.ex_valid   (dec_valid),
		.flush      (flush),
		.timer_busy (timer_busy),
		.dec_ready  (dec_ready),
		.accept     (accept),
		.timer_load (timer_load),
		.fence_dec  (fence_dec)
	);

	dec_ex_reg i_ex_reg (
		.cpu_clk      (cpu_clk),
		.cpu_rstn     (cpu_rstn),
		.bus          (i_bus),
		.accept       (accept),
		.ex_ready     (ex_ready),
		.flush        (flush),
		.dec_valid    (dec_valid),
		.alu_op_ex    (alu_op_ex),
		.src_data1_ex (src_data1_ex),
		.src_data2_ex (src_data2_ex),
		.pc_ex        (pc_ex),
		.rd_ex        (rd_ex),
		.rd_we_ex     (rd_we_ex)
	);

endmodule

`default_nettype wire

//--- design/fence_timer.sv
// fence drain counter; busy for fence_wait_cycles edges after load, clear wins over load
`default_nettype none

module fence_timer (
	input wire   cpu_clk,
	input wire   cpu_rstn,
	input wire   load,
	input wire   clear,
	output logic busy
);

	logic [dec_pkg::fence_cnt_w-1:0] count;

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
			count <= '0;
		else if (clear)
			count <= '0;
		else if (load)
			count <= dec_pkg::fence_cnt_init;
		else if (count != '0)
			count <= count - 1'b1; // saturates at zero
	end

	assign busy = (count != '0);

endmodule

`default_nettype wire

//--- design/gpr_file.sv
// x1..x31 register file, cleared at reset; reads are combinational, x0 reads zero and ignores writes
`default_nettype none

module gpr_file (
	input wire                           cpu_clk,
	input wire                           cpu_rstn,
	input wire                           wr_valid,
	input wire [dec_pkg::reg_idx_w-1:0]  wr_idx,
	input wire [dec_pkg::xlen-1:0]       wr_data,
	input wire [dec_pkg::reg_idx_w-1:0]  rs1,
	input wire [dec_pkg::reg_idx_w-1:0]  rs2,
	output logic [dec_pkg::xlen-1:0]     rdata1,
	output logic [dec_pkg::xlen-1:0]     rdata2
);

	logic [dec_pkg::xlen-1:0] regs [1:dec_pkg::gpr_num-1]; // no storage for x0

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < dec_pkg::gpr_num; i++)
				regs[i] <= '0;
		end
		else if (wr_valid && (wr_idx != '0))
		begin
			regs[wr_idx] <= wr_data;
		end
	end

	// no internal write-through, bypass is done in operand_select
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
// rv32i decoder for OP, OP-IMM, LUI, AUIPC, FENCE; anything else becomes a nop that writes no register
`default_nettype none

module instr_decoder (
	input wire [dec_pkg::instr_w-1:0] instr,
	input wire                        valid,
	dec_bus_if.decoder                bus
);

	logic [dec_pkg::instr_w-1:0] valid_instr;
	logic [6:0]                  opcode;
	logic [2:0]                  funct3;
	logic [6:0]                  funct7;
	logic                        is_lui;
	logic                        is_auipc;
	logic                        is_rr;
	logic                        is_ir;
	logic                        is_fence;
	logic                        f7_ok;
	dec_pkg::alu_op_t            alu_op;
	logic [dec_pkg::xlen-1:0]    imm_i;
	logic [dec_pkg::xlen-1:0]    imm_u;

	// a bubble decodes as opcode 0, i.e. a nop
	assign valid_instr = valid ? instr : '0;

	assign opcode = valid_instr[6:0];
	assign funct3 = valid_instr[14:12];
	assign funct7 = valid_instr[31:25];

	assign is_lui   = (opcode == dec_pkg::op_lui);
	assign is_auipc = (opcode == dec_pkg::op_auipc);
	assign is_rr    = (opcode == dec_pkg::op_alu_rr);
	assign is_ir    = (opcode == dec_pkg::op_alu_ir);
	assign is_fence = (opcode == dec_pkg::op_fence) &&
		((funct3 == dec_pkg::f3_fence) || (funct3 == dec_pkg::f3_fence_i));

	assign f7_ok = is_ir || (funct7 == dec_pkg::f7_base); // op-imm ignores funct7 here

	assign imm_i = {{20{valid_instr[31]}}, valid_instr[31:20]};
	assign imm_u = {valid_instr[31:12], 12'b0};

	always_comb
	begin
		alu_op = dec_pkg::alu_nop;
		if (is_lui || is_auipc)
			alu_op = dec_pkg::alu_add; // 0 + imm or pc + imm
		else if (is_rr || is_ir)
		begin
			case (funct3)
				dec_pkg::f3_add_sub:
					if (f7_ok)
						alu_op = dec_pkg::alu_add;
					else if (funct7 == dec_pkg::f7_alt)
						alu_op = dec_pkg::alu_sub;
				dec_pkg::f3_sll:  if (f7_ok) alu_op = dec_pkg::alu_sll;
				dec_pkg::f3_slt:  if (f7_ok) alu_op = dec_pkg::alu_slt;
				dec_pkg::f3_sltu: if (f7_ok) alu_op = dec_pkg::alu_sltu;
				dec_pkg::f3_xor:  if (f7_ok) alu_op = dec_pkg::alu_xor;
				dec_pkg::f3_or:   if (f7_ok) alu_op = dec_pkg::alu_or;
				dec_pkg::f3_and:  if (f7_ok) alu_op = dec_pkg::alu_and;
				// shift right picks srl/sra from funct7, for both formats
				dec_pkg::f3_srl_sra:
					if (funct7 == dec_pkg::f7_base)
						alu_op = dec_pkg::alu_srl;
					else if (funct7 == dec_pkg::f7_alt)
						alu_op = dec_pkg::alu_sra;
				default: alu_op = dec_pkg::alu_nop;
			endcase
		end
	end

	always_comb
	begin
		bus.instr.alu_op    = alu_op;
		bus.instr.rs1       = valid_instr[19:15];
		bus.instr.rs2       = valid_instr[24:20];
		bus.instr.rd        = valid_instr[11:7];
		bus.instr.rd_we     = (alu_op != dec_pkg::alu_nop);
		bus.instr.use_pc    = is_auipc;
		bus.instr.zero_src1 = is_lui;
		bus.instr.use_imm   = is_lui || is_auipc || is_ir;
		bus.instr.is_fence  = is_fence;
		if (is_ir)
			bus.instr.imm = imm_i;
		else if (is_lui || is_auipc)
			bus.instr.imm = imm_u;
		else
			bus.instr.imm = '0;
	end

endmodule

`default_nettype wire

//--- design/operand_select.sv
// operand mux with EX then WB bypass; assumes rd_ex/rd_we_ex come from the DEC-to-EX register
`default_nettype none

module operand_select (
	dec_bus_if.operand                  bus,
	input wire [dec_pkg::xlen-1:0]      rdata1,
	input wire [dec_pkg::xlen-1:0]      rdata2,
	input wire                          ex_valid,
	input wire [dec_pkg::reg_idx_w-1:0] rd_ex,
	input wire                          rd_we_ex,
	input wire [dec_pkg::xlen-1:0]      alu_result_ex,
	input wire                          wr_valid_wb,
	input wire [dec_pkg::reg_idx_w-1:0] rd_wb,
	input wire [dec_pkg::xlen-1:0]      wr_data_wb
);

	logic [dec_pkg::xlen-1:0] rs1_val;
	logic [dec_pkg::xlen-1:0] rs2_val;

	// youngest producer wins
	function automatic logic [dec_pkg::xlen-1:0] bypass(
		input logic [dec_pkg::reg_idx_w-1:0] idx,
		input logic [dec_pkg::xlen-1:0]      rf_val
	);
		if (idx == '0)
			return '0;
		else if (ex_valid && rd_we_ex && (idx == rd_ex))
			return alu_result_ex;
		else if (wr_valid_wb && (idx == rd_wb))
			return wr_data_wb;
		else
			return rf_val;
	endfunction

	always_comb
	begin
		rs1_val = bypass(bus.instr.rs1, rdata1);
		rs2_val = bypass(bus.instr.rs2, rdata2);

		if (bus.instr.use_pc)
			bus.src1 = bus.pc;
		else if (bus.instr.zero_src1)
			bus.src1 = '0;
		else
			bus.src1 = rs1_val;

		bus.src2 = bus.instr.use_imm ? bus.instr.imm : rs2_val;
	end

endmodule

`default_nettype wire

//--- design/stall_ctrl.sv
// decode hold FSM; ready needs EX room, accept is dropped under flush, fences hold for the timer
`default_nettype none

module stall_ctrl (
	input wire   cpu_clk,
	input wire   cpu_rstn,
	input wire   if_valid,
	input wire   is_fence,
	input wire   ex_ready,
	input wire   ex_valid,
	input wire   flush,
	input wire   timer_busy,
	output logic dec_ready,
	output logic accept,
	output logic timer_load,
	output logic fence_dec
);

	typedef enum logic {st_run, st_fence_hold} state_t;

	state_t state;
	state_t state_nxt;

	// hold releases as soon as the timer has run out
	assign dec_ready  = ((state == st_run) || !timer_busy) && (!ex_valid || ex_ready);
	assign accept     = if_valid && dec_ready && !flush;
	assign fence_dec  = accept && is_fence;
	assign timer_load = fence_dec;

	always_comb
	begin
		state_nxt = state;
		if (flush)
			state_nxt = st_run;
		else if (fence_dec)
			state_nxt = st_fence_hold; // also restarts the hold
		else if ((state == st_fence_hold) && !timer_busy)
			state_nxt = st_run;
	end

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
			state <= st_run;
		else
			state <= state_nxt;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
design/dec_pkg.sv
design/dec_bus_if.sv
design/instr_decoder.sv
design/gpr_file.sv
design/operand_select.sv
design/fence_timer.sv
design/stall_ctrl.sv
design/dec_ex_reg.sv
design/dec_stage.sv
verification/tb_dec_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs tb_dec_stage with Verilator, exit status 1 on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dec_stage -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]
then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vtb_dec_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]
then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" sim.log
then
	exit 1
fi
exit 0

//--- include/dec_tb_checks.svh
// checks and reference ALU for tb_dec_stage; included in the module body after its model variables
`ifndef DEC_TB_CHECKS_SVH
`define DEC_TB_CHECKS_SVH

// rv32i result of one ALU operation
function automatic logic [31:0] alu_ref(input dec_pkg::alu_op_t op, input logic [31:0] a,
	input logic [31:0] b);
	case (op)
		dec_pkg::alu_add:  return a + b;
		dec_pkg::alu_sub:  return a - b;
		dec_pkg::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
		dec_pkg::alu_sltu: return {31'b0, a < b};
		dec_pkg::alu_and:  return a & b;
		dec_pkg::alu_or:   return a | b;
		dec_pkg::alu_xor:  return a ^ b;
		dec_pkg::alu_sll:  return a << b[4:0];
		dec_pkg::alu_srl:  return a >> b[4:0];
		dec_pkg::alu_sra:  return $signed(a) >>> b[4:0];
		default:           return 32'h0;
	endcase
endfunction

// {funct7, funct3} from the rv32i encoding tables
function automatic logic [9:0] funct_of(input dec_pkg::alu_op_t op);
	case (op)
		dec_pkg::alu_sub:  return {7'b0100000, 3'b000};
		dec_pkg::alu_sll:  return {7'b0000000, 3'b001};
		dec_pkg::alu_slt:  return {7'b0000000, 3'b010};
		dec_pkg::alu_sltu: return {7'b0000000, 3'b011};
		dec_pkg::alu_xor:  return {7'b0000000, 3'b100};
		dec_pkg::alu_srl:  return {7'b0000000, 3'b101};
		dec_pkg::alu_sra:  return {7'b0100000, 3'b101};
		dec_pkg::alu_or:   return {7'b0000000, 3'b110};
		dec_pkg::alu_and:  return {7'b0000000, 3'b111};
		default:           return {7'b0000000, 3'b000}; // add
	endcase
endfunction

task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp)
	else
	begin
		errors++;
		$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_reset_state();
	check_eq("dec_valid in reset", 32'(dec_valid), 32'd0);
	check_eq("rd_we_ex in reset", 32'(rd_we_ex), 32'd0);
	check_eq("fence_dec in reset", 32'(fence_dec), 32'd0);
	check_eq("dec_ready in reset", 32'(dec_ready), 32'd1);
endtask

// registered EX outputs against the stage register model
task automatic check_ex_side();
	check_eq("dec_valid", 32'(dec_valid), 32'(exp_valid));
	if (exp_valid)
	begin
		check_eq("alu_op_ex", 32'(alu_op_ex), 32'(exp_op));
		check_eq("rd_ex", 32'(rd_ex), 32'(exp_rd));
		check_eq("rd_we_ex", 32'(rd_we_ex), 32'(exp_we));
		check_eq("pc_ex", pc_ex, exp_pc);
		if (exp_chk)
		begin
			check_eq("src_data1_ex", src_data1_ex, exp_s1);
			check_eq("src_data2_ex", src_data2_ex, exp_s2);
		end
	end
	else
		check_eq("rd_we_ex while idle", 32'(rd_we_ex), 32'd0);
	if (held) // item stalled by EX last cycle
	begin
		check_eq("src_data1_ex under back-pressure", src_data1_ex, held_s1);
		check_eq("src_data2_ex under back-pressure", src_data2_ex, held_s2);
		check_eq("pc_ex under back-pressure", pc_ex, held_pc);
		check_eq("op/rd under back-pressure", 32'({alu_op_ex, rd_ex, rd_we_ex}), 32'(held_ctl));
	end
endtask

`endif

//--- verification/tb_dec_stage.sv
// dec_stage testbench; EX and write-back are modelled here, operands checked against arch state
`default_nettype none

module tb_dec_stage;

	localparam int clk_period      = 20;
	localparam int reset_cycles    = 8;
	localparam int seed            = 74554;
	localparam int n_random        = 120;
	localparam int n_chain         = 60;
	localparam int n_press         = 80;
	localparam int directed_cycles = 30; // fence, flush and drain steps
	localparam int max_cycles      = reset_cycles + n_random + n_chain + n_press
		+ directed_cycles + 50;

	logic                 cpu_clk;
	logic                 cpu_rstn;
	logic                 if_valid;
	logic [31:0]          instr_dec;
	logic [31:0]          pc_dec;
	logic                 dec_ready;
	logic                 dec_valid;
	logic                 ex_ready;
	logic                 flush;
	logic [31:0]          alu_result_ex;
	logic                 wr_valid_wb;
	logic [4:0]           rd_wb;
	logic [31:0]          wr_data_wb;
	dec_pkg::alu_op_t     alu_op_ex;
	logic [31:0]          src_data1_ex;
	logic [31:0]          src_data2_ex;
	logic [31:0]          pc_ex;
	logic [4:0]           rd_ex;
	logic                 rd_we_ex;
	logic                 fence_dec;

	logic [31:0]          shadow [0:31]; // architectural registers
	logic [31:0]          pc;
	// instruction offered by the fetch model
	logic [31:0]          nx_instr;
	dec_pkg::alu_op_t     nx_op;
	logic [4:0]           nx_rd;
	logic [4:0]           nx_rs1;
	logic [4:0]           nx_rs2;
	logic                 nx_we;
	logic [1:0]           nx_src1; // 0 register, 1 pc, 2 zero
	logic                 nx_use_imm;
	logic [31:0]          nx_imm;
	logic                 nx_fence;
	// expected stage register
	logic                 exp_valid;
	dec_pkg::alu_op_t     exp_op;
	logic [31:0]          exp_s1;
	logic [31:0]          exp_s2;
	logic [31:0]          exp_pc;
	logic [4:0]           exp_rd;
	logic                 exp_we;
	logic                 exp_chk;
	logic                 exp_ready;
	int                   hold_cnt;
	logic                 wb_pend;
	logic [4:0]           wb_rd;
	logic [31:0]          wb_data;
	logic                 held;
	logic [31:0]          held_s1;
	logic [31:0]          held_s2;
	logic [31:0]          held_pc;
	logic [9:0]           held_ctl;
	logic                 last_accept;
	logic                 need_new;
	logic                 ready_seen;
	int                   fence_low;
	int                   errors;
	int                   checks;
	int                   cycles;

	dec_stage i_dut (
		.cpu_clk       (cpu_clk),
		.cpu_rstn      (cpu_rstn),
		.if_valid      (if_valid),
		.instr_dec     (instr_dec),
		.pc_dec        (pc_dec),
		.dec_ready     (dec_ready),
		.dec_valid     (dec_valid),
		.ex_ready      (ex_ready),
		.flush         (flush),
		.alu_result_ex (alu_result_ex),
		.wr_valid_wb   (wr_valid_wb),
		.rd_wb         (rd_wb),
		.wr_data_wb    (wr_data_wb),
		.alu_op_ex     (alu_op_ex),
		.src_data1_ex  (src_data1_ex),
		.src_data2_ex  (src_data2_ex),
		.pc_ex         (pc_ex),
		.rd_ex         (rd_ex),
		.rd_we_ex      (rd_we_ex),
		.fence_dec     (fence_dec)
	);

	`include "dec_tb_checks.svh"

	always #(clk_period / 2) cpu_clk = ~cpu_clk;

	always @(posedge cpu_clk)
	begin
		cycles++;
		if (cycles > max_cycles)
		begin
			$display("timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// kind 0 reg-reg, 1 reg-imm, 2 lui, 3 auipc, other fence
	task automatic gen_alu(input int kind, input dec_pkg::alu_op_t op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] rnd);
		dec_pkg::alu_op_t sel;
		logic [9:0]       f;
		logic [11:0]      imm12;
		sel = op;
		if (kind >= 2 || (kind == 1 && op == dec_pkg::alu_sub))
			sel = dec_pkg::alu_add; // no subi, lui/auipc add
		f = funct_of(sel);
		imm12 = rnd[11:0];
		if (sel == dec_pkg::alu_sll || sel == dec_pkg::alu_srl || sel == dec_pkg::alu_sra)
			imm12 = {f[9:3], rnd[4:0]};
		nx_op = sel;
		nx_rd = rd;
		nx_rs1 = rs1;
		nx_rs2 = rs2;
		nx_we = 1'b1;
		nx_fence = 1'b0;
		nx_src1 = 2'd0;
		nx_use_imm = (kind != 0);
		case (kind)
			0: nx_instr = {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
			1:
			begin
				nx_instr = {imm12, rs1, f[2:0], rd, 7'b0010011};
				nx_imm = {{20{imm12[11]}}, imm12};
			end
			2, 3:
			begin
				nx_instr = {rnd[31:12], rd, (kind == 2) ? 7'b0110111 : 7'b0010111};
				nx_src1 = (kind == 2) ? 2'd2 : 2'd1;
				nx_imm = {rnd[31:12], 12'h0};
			end
			default:
			begin
				nx_instr = 32'h0ff0000f; // fence iorw, iorw
				nx_op = dec_pkg::alu_nop;
				nx_rd = 5'd0;
				nx_we = 1'b0;
				nx_fence = 1'b1;
			end
		endcase
	endtask

	// mode 0 spreads over all registers, 1 and 2 crowd x0..x3 for hazards
	task automatic gen_random(input int mode);
		int kind;
		int hi;
		int lo;
		hi = (mode == 0) ? 31 : 3;
		lo = (mode == 0) ? 0 : 1;
		kind = (mode == 1) ? $urandom_range(1, 0) : $urandom_range(3, 0);
		gen_alu(kind, dec_pkg::alu_op_t'(4'($urandom_range(9, 0))), 5'($urandom_range(hi, lo)),
			5'($urandom_range(hi, 0)), 5'($urandom_range(hi, 0)), $urandom());
	endtask

	// one cycle from a falling edge to the next; checks, drives, advances the model
	task automatic run_cycle(input logic v, input logic rdy, input logic fl);
		logic accept;
		check_ex_side();
		alu_result_ex = alu_ref(alu_op_ex, src_data1_ex, src_data2_ex); // EX model
		wr_valid_wb = wb_pend;
		rd_wb = wb_rd;
		wr_data_wb = wb_data;
		if_valid = v;
		instr_dec = v ? nx_instr : 32'h0;
		pc_dec = pc;
		ex_ready = rdy;
		flush = fl;
		exp_ready = (hold_cnt == 0) && (!exp_valid || rdy);
		#1;
		ready_seen = dec_ready;
		check_eq("dec_ready", 32'(dec_ready), 32'(exp_ready));
		accept = v && exp_ready && !fl;
		check_eq("fence_dec", 32'(fence_dec), 32'(accept && nx_fence));
		wb_pend = dec_valid && rdy && rd_we_ex; // retires one cycle after the take
		wb_rd = rd_ex;
		wb_data = alu_result_ex;
		held = dec_valid && !rdy && !fl;
		held_s1 = src_data1_ex;
		held_s2 = src_data2_ex;
		held_pc = pc_ex;
		held_ctl = {alu_op_ex, rd_ex, rd_we_ex};
		if (fl)
			hold_cnt = 0;
		else if (accept && nx_fence)
			hold_cnt = dec_pkg::fence_wait_cycles;
		else if (hold_cnt > 0)
			hold_cnt--;
		if (fl)
			exp_valid = 1'b0;
		else if (accept)
		begin
			exp_valid = 1'b1;
			exp_op = nx_op;
			exp_rd = nx_rd;
			exp_we = nx_we;
			exp_pc = pc;
			exp_chk = !nx_fence;
			exp_s1 = (nx_src1 == 2'd1) ? pc : ((nx_src1 == 2'd2) ? 32'h0 : shadow[nx_rs1]);
			exp_s2 = nx_use_imm ? nx_imm : shadow[nx_rs2];
			if (nx_we && nx_rd != 5'd0)
				shadow[nx_rd] = alu_ref(nx_op, exp_s1, exp_s2);
			pc = pc + 32'd4;
		end
		else if (rdy)
			exp_valid = 1'b0;
		last_accept = accept;
		@(negedge cpu_clk);
	endtask

	// the offered instruction stays until accepted
	task automatic fetch_run(input int n, input int mode);
		logic rdy;
		logic v;
		for (int i = 0; i < n; i++)
		begin
			if (need_new)
				gen_random(mode);
			rdy = (mode != 2) || ($urandom_range(2, 0) != 0);
			v = (mode != 2) || ($urandom_range(4, 0) != 0);
			run_cycle(v, rdy, 1'b0);
			need_new = last_accept;
		end
	endtask

	initial
	begin
		void'($urandom(seed));
		cpu_clk = 1'b0;
		cpu_rstn = 1'b0;
		if_valid = 1'b0;
		instr_dec = 32'h0;
		pc_dec = 32'h0;
		ex_ready = 1'b0;
		flush = 1'b0;
		alu_result_ex = 32'h0;
		wr_valid_wb = 1'b0;
		rd_wb = 5'd0;
		wr_data_wb = 32'h0;
		for (int i = 0; i < 32; i++)
			shadow[i] = 32'h0;
		pc = 32'h0000_1000;
		exp_valid = 1'b0;
		hold_cnt = 0;
		wb_pend = 1'b0;
		wb_rd = 5'd0;
		wb_data = 32'h0;
		held = 1'b0;
		need_new = 1'b1;
		errors = 0;
		checks = 0;
		cycles = 0;
		repeat (reset_cycles)
		begin
			@(posedge cpu_clk);
			#1;
			check_reset_state();
		end
		@(negedge cpu_clk);
		cpu_rstn = 1'b1;

		fetch_run(n_random, 0); // decode and operands
		fetch_run(n_chain, 1);  // dependent chains, EX and WB bypass
		fetch_run(n_press, 2);  // random ex_ready and bubbles

		gen_alu(4, dec_pkg::alu_nop, 5'd0, 5'd0, 5'd0, 32'h0);
		run_cycle(1'b1, 1'b1, 1'b0);
		check_eq("dec_ready for the fence", 32'(ready_seen), 32'd1);
		fence_low = 0;
		gen_random(0);
		for (int i = 0; i < dec_pkg::fence_wait_cycles + 3; i++)
		begin
			run_cycle(1'b1, 1'b1, 1'b0);
			if (!ready_seen)
				fence_low++;
			if (last_accept)
				gen_random(0);
		end
		check_eq("cycles not ready after fence", 32'(fence_low), 32'(dec_pkg::fence_wait_cycles));

		// flush drops the offered instruction, the older one still leaves
		gen_alu(0, dec_pkg::alu_add, 5'd7, 5'd1, 5'd2, 32'h0);
		run_cycle(1'b1, 1'b1, 1'b0);
		gen_alu(0, dec_pkg::alu_xor, 5'd9, 5'd7, 5'd7, 32'h0);
		run_cycle(1'b1, 1'b1, 1'b1);
		run_cycle(1'b0, 1'b1, 1'b0);
		run_cycle(1'b0, 1'b1, 1'b0);

		// flush in the middle of a fence hold
		gen_alu(4, dec_pkg::alu_nop, 5'd0, 5'd0, 5'd0, 32'h0);
		run_cycle(1'b1, 1'b1, 1'b0);
		gen_random(0);
		run_cycle(1'b1, 1'b1, 1'b0);
		run_cycle(1'b1, 1'b1, 1'b0);
		run_cycle(1'b1, 1'b1, 1'b1);
		gen_random(0);
		run_cycle(1'b1, 1'b1, 1'b0);
		check_eq("dec_ready right after flush", 32'(ready_seen), 32'd1);
		repeat (3)
			run_cycle(1'b0, 1'b1, 1'b0);

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
